//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Instruction memory depth as a word address width
`define IMEM_AW 8

// Data memory depth as a word address width
`define DMEM_AW 8

// Address bit that selects the memory-mapped I/O region
`define MMIO_BIT 15

// Fetch address after reset and after boot
`define RESET_PC 32'h0000_0000

`endif

//--- isa_pkg.sv
package isa_pkg;

	// RV32I major opcodes for the supported subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011
	} opcode_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e    opcode;
	} s_fmt_t;

	// Branch offset bits are scattered, bit 0 is implied zero
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	// One instruction word, seen through every encoding format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv_instr_t;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

	typedef logic [31:0] word_t;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLTU,
		SLL,
		SRL,
		SRA,
		PASS_B
	} alu_op_e;

	// Source of the value written back to the register file
	typedef enum logic [1:0] {
		ALU,
		MEM,
		PC4
	} wb_sel_e;

	// Operand source for bypassing
	typedef enum logic [1:0] {
		REG,
		EXMEM,
		MEMWB
	} fwd_sel_e;

endpackage

//--- fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module fetch (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               debug,
	input  logic               boot_req,
	input  pipe_pkg::word_t    boot_addr,
	input  pipe_pkg::word_t    boot_data,
	output logic               boot_ack,
	input  logic               stall,
	input  logic               flush_ifid,
	input  logic               redirect,
	input  pipe_pkg::word_t    redirect_pc,
	output isa_pkg::rv_instr_t ifid_instr,
	output pipe_pkg::word_t    ifid_pc,
	output pipe_pkg::word_t    ifid_pc4,
	output logic               ifid_valid,
	output logic               ifid_is_ecall
);

	logic [31:0]        imem [2**`IMEM_AW];
	pipe_pkg::word_t    pc;
	pipe_pkg::word_t    pc4;
	isa_pkg::rv_instr_t f_instr;
	logic               f_ecall;
	logic               ecall_seen;

	assign pc4     = pc + 32'd4;
	assign f_instr = imem[pc[`IMEM_AW+1:2]];
	assign f_ecall = (f_instr.r.opcode == isa_pkg::SYSTEM) && (f_instr.r.funct3 == 3'b000);

	// Host writes one word per req/ack cycle while debug is high
	always_ff @(posedge clk) begin
		if (debug && boot_req && !boot_ack)
			imem[boot_addr[`IMEM_AW+1:2]] <= boot_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			boot_ack <= 1'b0;
		end else if (debug && boot_req && !boot_ack) begin
			boot_ack <= 1'b1;
		end else if (!boot_req && boot_ack) begin
			boot_ack <= 1'b0;
		end
	end

	// PC and IF/ID control state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc            <= `RESET_PC;
			ecall_seen    <= 1'b0;
			ifid_valid    <= 1'b0;
			ifid_is_ecall <= 1'b0;
		end else if (debug) begin
			pc            <= `RESET_PC;
			ecall_seen    <= 1'b0;
			ifid_valid    <= 1'b0;
			ifid_is_ecall <= 1'b0;
		end else if (!stall) begin
			if (flush_ifid || ecall_seen) begin
				ifid_valid    <= 1'b0;
				ifid_is_ecall <= 1'b0;
			end else begin
				ifid_valid    <= 1'b1;
				ifid_is_ecall <= f_ecall;
				ecall_seen    <= f_ecall;
			end
			// Nothing issues past a fetched ECALL
			if (redirect)
				pc <= redirect_pc;
			else if (!ecall_seen && !f_ecall)
				pc <= pc4;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifid_instr <= f_instr;
			ifid_pc    <= pc;
			ifid_pc4   <= pc4;
		end
	end

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
	input  logic               clk,
	input  logic               arst_n,
	input  isa_pkg::rv_instr_t ifid_instr,
	input  pipe_pkg::word_t    ifid_pc,
	input  pipe_pkg::word_t    ifid_pc4,
	input  logic               ifid_valid,
	input  logic               ifid_is_ecall,
	input  logic               stall,
	input  logic               wb_we,
	input  logic [4:0]         wb_rd,
	input  pipe_pkg::word_t    wb_data,
	input  logic               exmem_we,
	input  logic [4:0]         exmem_rd,
	input  pipe_pkg::word_t    exmem_result,
	output logic               redirect,
	output pipe_pkg::word_t    redirect_pc,
	output pipe_pkg::word_t    idex_rs1_data,
	output pipe_pkg::word_t    idex_rs2_data,
	output pipe_pkg::word_t    idex_imm,
	output pipe_pkg::alu_op_e  idex_alu_op,
	output logic               idex_use_imm,
	output logic               idex_use_pc,
	output logic               idex_reg_we,
	output logic               idex_mem_re,
	output logic               idex_mem_we,
	output pipe_pkg::wb_sel_e  idex_wb_sel,
	output isa_pkg::rv_instr_t idex_instr,
	output pipe_pkg::word_t    idex_pc,
	output pipe_pkg::word_t    idex_pc4,
	output logic               idex_is_ecall
);

	pipe_pkg::word_t   rf [32];
	logic [4:0]        rs1;
	logic [4:0]        rs2;
	pipe_pkg::word_t   rf1;
	pipe_pkg::word_t   rf2;
	pipe_pkg::fwd_sel_e sel1;
	pipe_pkg::fwd_sel_e sel2;
	pipe_pkg::word_t   br_a;
	pipe_pkg::word_t   br_b;
	logic              br_taken;
	pipe_pkg::word_t   imm_i;
	pipe_pkg::word_t   imm_s;
	pipe_pkg::word_t   imm_b;
	pipe_pkg::word_t   imm_u;
	pipe_pkg::word_t   imm_j;
	pipe_pkg::word_t   imm;
	pipe_pkg::alu_op_e alu_op;
	pipe_pkg::wb_sel_e wb_sel;
	logic              use_imm;
	logic              use_pc;
	logic              reg_we;
	logic              mem_re;
	logic              mem_we;

	function automatic pipe_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic f7b5,
							  input logic is_reg);
		case (f3)
			3'b000: return (is_reg && f7b5) ? pipe_pkg::SUB : pipe_pkg::ADD;
			3'b001: return pipe_pkg::SLL;
			3'b010: return pipe_pkg::SLT;
			3'b011: return pipe_pkg::SLTU;
			3'b100: return pipe_pkg::XOR;
			3'b101: return f7b5 ? pipe_pkg::SRA : pipe_pkg::SRL;
			3'b110: return pipe_pkg::OR;
			default: return pipe_pkg::AND;
		endcase
	endfunction

	assign rs1 = ifid_instr.r.rs1;
	assign rs2 = ifid_instr.r.rs2;

	// Register file, x0 reads zero and a same-cycle write is bypassed
	always_ff @(posedge clk) begin
		if (wb_we && wb_rd != 5'd0)
			rf[wb_rd] <= wb_data;
	end

	assign rf1 = (rs1 == 5'd0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : rf[rs1];
	assign rf2 = (rs2 == 5'd0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : rf[rs2];

	// Branch operand bypass, youngest producer first
	always_comb begin
		sel1 = pipe_pkg::REG;
		sel2 = pipe_pkg::REG;
		if (rs1 != 5'd0 && exmem_we && exmem_rd == rs1)
			sel1 = pipe_pkg::EXMEM;
		else if (rs1 != 5'd0 && wb_we && wb_rd == rs1)
			sel1 = pipe_pkg::MEMWB;
		if (rs2 != 5'd0 && exmem_we && exmem_rd == rs2)
			sel2 = pipe_pkg::EXMEM;
		else if (rs2 != 5'd0 && wb_we && wb_rd == rs2)
			sel2 = pipe_pkg::MEMWB;
	end

	assign br_a = (sel1 == pipe_pkg::EXMEM) ? exmem_result :
		      (sel1 == pipe_pkg::MEMWB) ? wb_data : rf1;
	assign br_b = (sel2 == pipe_pkg::EXMEM) ? exmem_result :
		      (sel2 == pipe_pkg::MEMWB) ? wb_data : rf2;

	assign imm_i = {{20{ifid_instr.i.imm_11_0[11]}}, ifid_instr.i.imm_11_0};
	assign imm_s = {{20{ifid_instr.s.imm_11_5[6]}}, ifid_instr.s.imm_11_5, ifid_instr.s.imm_4_0};
	assign imm_b = {{20{ifid_instr.b.imm_12}}, ifid_instr.b.imm_11, ifid_instr.b.imm_10_5,
			ifid_instr.b.imm_4_1, 1'b0};
	assign imm_u = {ifid_instr.u.imm_31_12, 12'd0};
	assign imm_j = {{12{ifid_instr.j.imm_20}}, ifid_instr.j.imm_19_12, ifid_instr.j.imm_11,
			ifid_instr.j.imm_10_1, 1'b0};

	always_comb begin
		case (ifid_instr.b.funct3)
			3'b000:  br_taken = (br_a == br_b);
			3'b001:  br_taken = (br_a != br_b);
			3'b100:  br_taken = ($signed(br_a) < $signed(br_b));
			3'b101:  br_taken = ($signed(br_a) >= $signed(br_b));
			default: br_taken = 1'b0;
		endcase
	end

	// Predict not taken, so any taken control transfer redirects fetch
	always_comb begin
		redirect    = 1'b0;
		redirect_pc = ifid_pc + imm_b;
		if (ifid_valid) begin
			case (ifid_instr.r.opcode)
				isa_pkg::BRANCH: redirect = br_taken;
				isa_pkg::JAL: begin
					redirect    = 1'b1;
					redirect_pc = ifid_pc + imm_j;
				end
				isa_pkg::JALR: begin
					redirect    = 1'b1;
					redirect_pc = (br_a + imm_i) & ~32'd1;
				end
				default: redirect = 1'b0;
			endcase
		end
	end

	always_comb begin
		alu_op  = pipe_pkg::ADD;
		wb_sel  = pipe_pkg::ALU;
		imm     = imm_i;
		use_imm = 1'b0;
		use_pc  = 1'b0;
		reg_we  = 1'b0;
		mem_re  = 1'b0;
		mem_we  = 1'b0;
		case (ifid_instr.r.opcode)
			isa_pkg::OP: begin
				reg_we = 1'b1;
				alu_op = alu_decode(ifid_instr.r.funct3, ifid_instr.r.funct7[5], 1'b1);
			end
			isa_pkg::OP_IMM: begin
				reg_we  = 1'b1;
				use_imm = 1'b1;
				alu_op  = alu_decode(ifid_instr.r.funct3, ifid_instr.r.funct7[5], 1'b0);
			end
			isa_pkg::LUI: begin
				reg_we  = 1'b1;
				use_imm = 1'b1;
				imm     = imm_u;
				alu_op  = pipe_pkg::PASS_B;
			end
			isa_pkg::AUIPC: begin
				reg_we  = 1'b1;
				use_imm = 1'b1;
				use_pc  = 1'b1;
				imm     = imm_u;
			end
			isa_pkg::LOAD: begin
				reg_we  = 1'b1;
				use_imm = 1'b1;
				mem_re  = 1'b1;
				wb_sel  = pipe_pkg::MEM;
			end
			isa_pkg::STORE: begin
				use_imm = 1'b1;
				mem_we  = 1'b1;
				imm     = imm_s;
			end
			isa_pkg::JAL, isa_pkg::JALR: begin
				reg_we = 1'b1;
				wb_sel = pipe_pkg::PC4;
			end
			default: reg_we = 1'b0;
		endcase
	end

	// ID/EX controls, a stall or an empty slot becomes a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			idex_reg_we   <= 1'b0;
			idex_mem_re   <= 1'b0;
			idex_mem_we   <= 1'b0;
			idex_is_ecall <= 1'b0;
		end else begin
			idex_reg_we   <= reg_we & ifid_valid & ~stall;
			idex_mem_re   <= mem_re & ifid_valid & ~stall;
			idex_mem_we   <= mem_we & ifid_valid & ~stall;
			idex_is_ecall <= ifid_is_ecall & ifid_valid & ~stall;
		end
	end

	always_ff @(posedge clk) begin
		idex_rs1_data <= rf1;
		idex_rs2_data <= rf2;
		idex_imm      <= imm;
		idex_alu_op   <= alu_op;
		idex_use_imm  <= use_imm;
		idex_use_pc   <= use_pc;
		idex_wb_sel   <= wb_sel;
		idex_instr    <= ifid_instr;
		idex_pc       <= ifid_pc;
		idex_pc4      <= ifid_pc4;
	end

endmodule

`default_nettype wire

//--- execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  logic               clk,
	input  logic               arst_n,
	input  pipe_pkg::word_t    idex_rs1_data,
	input  pipe_pkg::word_t    idex_rs2_data,
	input  pipe_pkg::word_t    idex_imm,
	input  pipe_pkg::alu_op_e  idex_alu_op,
	input  logic               idex_use_imm,
	input  logic               idex_use_pc,
	input  logic               idex_reg_we,
	input  logic               idex_mem_re,
	input  logic               idex_mem_we,
	input  pipe_pkg::wb_sel_e  idex_wb_sel,
	input  isa_pkg::rv_instr_t idex_instr,
	input  pipe_pkg::word_t    idex_pc,
	input  pipe_pkg::word_t    idex_pc4,
	input  logic               idex_is_ecall,
	input  logic               exmem_we,
	input  logic [4:0]         exmem_rd,
	input  pipe_pkg::word_t    exmem_result,
	input  logic               wb_we,
	input  logic [4:0]         wb_rd,
	input  pipe_pkg::word_t    wb_data,
	output pipe_pkg::word_t    exmem_result_reg,
	output pipe_pkg::word_t    exmem_store_data,
	output logic               exmem_reg_we,
	output logic               exmem_mem_re,
	output logic               exmem_mem_we,
	output pipe_pkg::wb_sel_e  exmem_wb_sel,
	output logic [4:0]         exmem_rd_reg,
	output pipe_pkg::word_t    exmem_pc4,
	output logic               exmem_is_ecall
);

	logic [4:0]         rs1;
	logic [4:0]         rs2;
	pipe_pkg::fwd_sel_e sel_a;
	pipe_pkg::fwd_sel_e sel_b;
	pipe_pkg::word_t    fwd_a;
	pipe_pkg::word_t    fwd_b;
	pipe_pkg::word_t    op_a;
	pipe_pkg::word_t    op_b;
	pipe_pkg::word_t    alu_y;
	pipe_pkg::word_t    result;

	assign rs1 = idex_instr.r.rs1;
	assign rs2 = idex_instr.r.rs2;

	// EX/MEM holds the younger producer, so it wins over MEM/WB
	always_comb begin
		sel_a = pipe_pkg::REG;
		sel_b = pipe_pkg::REG;
		if (rs1 != 5'd0 && exmem_we && exmem_rd == rs1)
			sel_a = pipe_pkg::EXMEM;
		else if (rs1 != 5'd0 && wb_we && wb_rd == rs1)
			sel_a = pipe_pkg::MEMWB;
		if (rs2 != 5'd0 && exmem_we && exmem_rd == rs2)
			sel_b = pipe_pkg::EXMEM;
		else if (rs2 != 5'd0 && wb_we && wb_rd == rs2)
			sel_b = pipe_pkg::MEMWB;
	end

	assign fwd_a = (sel_a == pipe_pkg::EXMEM) ? exmem_result :
		       (sel_a == pipe_pkg::MEMWB) ? wb_data : idex_rs1_data;
	assign fwd_b = (sel_b == pipe_pkg::EXMEM) ? exmem_result :
		       (sel_b == pipe_pkg::MEMWB) ? wb_data : idex_rs2_data;

	assign op_a = idex_use_pc ? idex_pc : fwd_a;
	assign op_b = idex_use_imm ? idex_imm : fwd_b;

	always_comb begin
		case (idex_alu_op)
			pipe_pkg::ADD:    alu_y = op_a + op_b;
			pipe_pkg::SUB:    alu_y = op_a - op_b;
			pipe_pkg::AND:    alu_y = op_a & op_b;
			pipe_pkg::OR:     alu_y = op_a | op_b;
			pipe_pkg::XOR:    alu_y = op_a ^ op_b;
			pipe_pkg::SLT:    alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
			pipe_pkg::SLTU:   alu_y = {31'd0, op_a < op_b};
			pipe_pkg::SLL:    alu_y = op_a << op_b[4:0];
			pipe_pkg::SRL:    alu_y = op_a >> op_b[4:0];
			pipe_pkg::SRA:    alu_y = $signed(op_a) >>> op_b[4:0];
			pipe_pkg::PASS_B: alu_y = op_b;
			default:          alu_y = '0;
		endcase
	end

	// Link value goes down the result path so it can be forwarded
	assign result = (idex_wb_sel == pipe_pkg::PC4) ? idex_pc4 : alu_y;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exmem_reg_we   <= 1'b0;
			exmem_mem_re   <= 1'b0;
			exmem_mem_we   <= 1'b0;
			exmem_is_ecall <= 1'b0;
		end else begin
			exmem_reg_we   <= idex_reg_we;
			exmem_mem_re   <= idex_mem_re;
			exmem_mem_we   <= idex_mem_we;
			exmem_is_ecall <= idex_is_ecall;
		end
	end

	always_ff @(posedge clk) begin
		exmem_result_reg <= result;
		exmem_store_data <= fwd_b;
		exmem_wb_sel     <= idex_wb_sel;
		exmem_rd_reg     <= idex_instr.r.rd;
		exmem_pc4        <= idex_pc4;
	end

endmodule

`default_nettype wire

//--- memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module memory (
	input  logic              clk,
	input  logic              arst_n,
	input  pipe_pkg::word_t   exmem_result_reg,
	input  pipe_pkg::word_t   exmem_store_data,
	input  logic              exmem_reg_we,
	input  logic              exmem_mem_re,
	input  logic              exmem_mem_we,
	input  pipe_pkg::wb_sel_e exmem_wb_sel,
	input  logic [4:0]        exmem_rd_reg,
	input  pipe_pkg::word_t   exmem_pc4,
	input  logic              exmem_is_ecall,
	input  pipe_pkg::word_t   joystick_data,
	output logic              mmio_we,
	output pipe_pkg::word_t   mmio_addr,
	output pipe_pkg::word_t   mmio_data,
	output logic              halt,
	output logic              wb_we,
	output logic [4:0]        wb_rd,
	output pipe_pkg::word_t   wb_data
);

	pipe_pkg::word_t   dmem [2**`DMEM_AW];
	logic              is_mmio;
	pipe_pkg::word_t   load_data;
	pipe_pkg::word_t   memwb_result;
	pipe_pkg::word_t   memwb_load;
	pipe_pkg::word_t   memwb_pc4;
	pipe_pkg::wb_sel_e memwb_wb_sel;

	assign is_mmio = exmem_result_reg[`MMIO_BIT];

	// Stores to the I/O region leave the core instead of hitting data memory
	assign mmio_we   = exmem_mem_we & is_mmio;
	assign mmio_addr = exmem_result_reg;
	assign mmio_data = exmem_store_data;

	always_ff @(posedge clk) begin
		if (exmem_mem_we && !is_mmio)
			dmem[exmem_result_reg[`DMEM_AW+1:2]] <= exmem_store_data;
	end

	assign load_data = is_mmio ? joystick_data : dmem[exmem_result_reg[`DMEM_AW+1:2]];

	// Halt sets as the ECALL enters MEM/WB and holds until reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_we <= 1'b0;
			halt  <= 1'b0;
		end else begin
			wb_we <= exmem_reg_we;
			halt  <= halt | exmem_is_ecall;
		end
	end

	always_ff @(posedge clk) begin
		memwb_result <= exmem_result_reg;
		memwb_load   <= exmem_mem_re ? load_data : '0;
		memwb_pc4    <= exmem_pc4;
		memwb_wb_sel <= exmem_wb_sel;
		wb_rd        <= exmem_rd_reg;
	end

	always_comb begin
		case (memwb_wb_sel)
			pipe_pkg::MEM: wb_data = memwb_load;
			pipe_pkg::PC4: wb_data = memwb_pc4;
			default:       wb_data = memwb_result;
		endcase
	end

endmodule

`default_nettype wire

//--- hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  isa_pkg::rv_instr_t id_instr,
	input  logic               id_valid,
	input  logic [4:0]         ex_rd,
	input  logic               ex_reg_we,
	input  logic               ex_mem_re,
	input  logic [4:0]         mem_rd,
	input  logic               mem_mem_re,
	input  logic               redirect,
	output logic               stall,
	output logic               flush_ifid
);

	isa_pkg::opcode_e op;
	logic             uses_rs1;
	logic             uses_rs2;
	logic             is_br;
	logic             hit_ex;
	logic             hit_mem;

	assign op = id_instr.r.opcode;

	assign uses_rs1 = (op == isa_pkg::OP) || (op == isa_pkg::OP_IMM) || (op == isa_pkg::LOAD) ||
			  (op == isa_pkg::STORE) || (op == isa_pkg::BRANCH) || (op == isa_pkg::JALR);
	assign uses_rs2 = (op == isa_pkg::OP) || (op == isa_pkg::STORE) || (op == isa_pkg::BRANCH);

	// These resolve in decode and need their operands a stage early
	assign is_br = (op == isa_pkg::BRANCH) || (op == isa_pkg::JALR);

	assign hit_ex  = (ex_rd != 5'd0) && ((uses_rs1 && id_instr.r.rs1 == ex_rd) ||
					     (uses_rs2 && id_instr.r.rs2 == ex_rd));
	assign hit_mem = (mem_rd != 5'd0) && ((uses_rs1 && id_instr.r.rs1 == mem_rd) ||
					      (uses_rs2 && id_instr.r.rs2 == mem_rd));

	assign stall = id_valid && ((ex_mem_re && hit_ex) ||
				    (is_br && ex_reg_we && hit_ex) ||
				    (is_br && mem_mem_re && hit_mem));

	assign flush_ifid = redirect & ~stall;

endmodule

`default_nettype wire

//--- cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            debug,
	input  logic            boot_req,
	input  pipe_pkg::word_t boot_addr,
	input  pipe_pkg::word_t boot_data,
	input  pipe_pkg::word_t joystick_data,
	output logic            boot_ack,
	output logic            mmio_we,
	output pipe_pkg::word_t mmio_addr,
	output pipe_pkg::word_t mmio_data,
	output logic            halt
);

	// Fetch to decode
	isa_pkg::rv_instr_t ifid_instr;
	pipe_pkg::word_t    ifid_pc;
	pipe_pkg::word_t    ifid_pc4;
	logic               ifid_valid;
	logic               ifid_is_ecall;

	// Decode to execute
	pipe_pkg::word_t    idex_rs1_data;
	pipe_pkg::word_t    idex_rs2_data;
	pipe_pkg::word_t    idex_imm;
	pipe_pkg::alu_op_e  idex_alu_op;
	logic               idex_use_imm;
	logic               idex_use_pc;
	logic               idex_reg_we;
	logic               idex_mem_re;
	logic               idex_mem_we;
	pipe_pkg::wb_sel_e  idex_wb_sel;
	isa_pkg::rv_instr_t idex_instr;
	pipe_pkg::word_t    idex_pc;
	pipe_pkg::word_t    idex_pc4;
	logic               idex_is_ecall;

	// Execute to memory
	pipe_pkg::word_t    exmem_result;
	pipe_pkg::word_t    exmem_store_data;
	logic               exmem_we;
	logic               exmem_mem_re;
	logic               exmem_mem_we;
	pipe_pkg::wb_sel_e  exmem_wb_sel;
	logic [4:0]         exmem_rd;
	pipe_pkg::word_t    exmem_pc4;
	logic               exmem_is_ecall;

	// Writeback and control
	logic               wb_we;
	logic [4:0]         wb_rd;
	pipe_pkg::word_t    wb_data;
	logic               redirect;
	pipe_pkg::word_t    redirect_pc;
	logic               stall;
	logic               flush_ifid;

	fetch u_fetch (
		.clk(clk), .arst_n(arst_n), .debug(debug),
		.boot_req(boot_req), .boot_addr(boot_addr), .boot_data(boot_data),
		.boot_ack(boot_ack), .stall(stall), .flush_ifid(flush_ifid),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.ifid_instr(ifid_instr), .ifid_pc(ifid_pc), .ifid_pc4(ifid_pc4),
		.ifid_valid(ifid_valid), .ifid_is_ecall(ifid_is_ecall)
	);

	decode u_decode (
		.clk(clk), .arst_n(arst_n),
		.ifid_instr(ifid_instr), .ifid_pc(ifid_pc), .ifid_pc4(ifid_pc4),
		.ifid_valid(ifid_valid), .ifid_is_ecall(ifid_is_ecall), .stall(stall),
		.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.exmem_we(exmem_we), .exmem_rd(exmem_rd), .exmem_result(exmem_result),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.idex_rs1_data(idex_rs1_data), .idex_rs2_data(idex_rs2_data),
		.idex_imm(idex_imm), .idex_alu_op(idex_alu_op),
		.idex_use_imm(idex_use_imm), .idex_use_pc(idex_use_pc),
		.idex_reg_we(idex_reg_we), .idex_mem_re(idex_mem_re), .idex_mem_we(idex_mem_we),
		.idex_wb_sel(idex_wb_sel), .idex_instr(idex_instr), .idex_pc(idex_pc),
		.idex_pc4(idex_pc4), .idex_is_ecall(idex_is_ecall)
	);

	execute u_execute (
		.clk(clk), .arst_n(arst_n),
		.idex_rs1_data(idex_rs1_data), .idex_rs2_data(idex_rs2_data),
		.idex_imm(idex_imm), .idex_alu_op(idex_alu_op),
		.idex_use_imm(idex_use_imm), .idex_use_pc(idex_use_pc),
		.idex_reg_we(idex_reg_we), .idex_mem_re(idex_mem_re), .idex_mem_we(idex_mem_we),
		.idex_wb_sel(idex_wb_sel), .idex_instr(idex_instr), .idex_pc(idex_pc),
		.idex_pc4(idex_pc4), .idex_is_ecall(idex_is_ecall),
		.exmem_we(exmem_we), .exmem_rd(exmem_rd), .exmem_result(exmem_result),
		.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.exmem_result_reg(exmem_result), .exmem_store_data(exmem_store_data),
		.exmem_reg_we(exmem_we), .exmem_mem_re(exmem_mem_re), .exmem_mem_we(exmem_mem_we),
		.exmem_wb_sel(exmem_wb_sel), .exmem_rd_reg(exmem_rd), .exmem_pc4(exmem_pc4),
		.exmem_is_ecall(exmem_is_ecall)
	);

	memory u_memory (
		.clk(clk), .arst_n(arst_n),
		.exmem_result_reg(exmem_result), .exmem_store_data(exmem_store_data),
		.exmem_reg_we(exmem_we), .exmem_mem_re(exmem_mem_re), .exmem_mem_we(exmem_mem_we),
		.exmem_wb_sel(exmem_wb_sel), .exmem_rd_reg(exmem_rd), .exmem_pc4(exmem_pc4),
		.exmem_is_ecall(exmem_is_ecall), .joystick_data(joystick_data),
		.mmio_we(mmio_we), .mmio_addr(mmio_addr), .mmio_data(mmio_data), .halt(halt),
		.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	hazard_unit u_hazard_unit (
		.id_instr(ifid_instr), .id_valid(ifid_valid),
		.ex_rd(idex_instr.r.rd), .ex_reg_we(idex_reg_we), .ex_mem_re(idex_mem_re),
		.mem_rd(exmem_rd), .mem_mem_re(exmem_mem_re), .redirect(redirect),
		.stall(stall), .flush_ifid(flush_ifid)
	);

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;

	localparam int TIMEOUT = 2000;

	// sw x0, -2048(x0) lands in the I/O region whatever the registers hold
	localparam logic [31:0] STRAY_STORE = 32'h8000_2023;

	logic            clk;
	logic            arst_n;
	logic            debug;
	logic            boot_req;
	pipe_pkg::word_t boot_addr;
	pipe_pkg::word_t boot_data;
	pipe_pkg::word_t joystick_data;
	logic            boot_ack;
	logic            mmio_we;
	pipe_pkg::word_t mmio_addr;
	pipe_pkg::word_t mmio_data;
	logic            halt;

	// Program image and the expected memory-mapped writes in program order
	pipe_pkg::word_t prog_addr[$];
	pipe_pkg::word_t prog_word[$];
	pipe_pkg::word_t exp_addr[$];
	pipe_pkg::word_t exp_data[$];

	int errors;
	int timeouts;
	int seen;

	cpu dut (
		.clk(clk), .arst_n(arst_n), .debug(debug),
		.boot_req(boot_req), .boot_addr(boot_addr), .boot_data(boot_data),
		.joystick_data(joystick_data), .boot_ack(boot_ack),
		.mmio_we(mmio_we), .mmio_addr(mmio_addr), .mmio_data(mmio_data), .halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_word(input string name, input pipe_pkg::word_t exp,
				  input pipe_pkg::word_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Error %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic load_patterns();
		int              fd;
		int              n;
		logic [7:0]      kind;
		pipe_pkg::word_t a;
		pipe_pkg::word_t b;
		pipe_pkg::word_t next_addr;
		logic [1023:0]   line;
		fd = $fopen("cpu_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open cpu_patterns.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, " %c", kind);
			if (n != 1)
				break;
			if (kind == "#") begin
				n = $fgets(line, fd);
			end else begin
				n = $fscanf(fd, " %h %h", a, b);
				case (kind)
					"P": begin
						prog_addr.push_back(a);
						prog_word.push_back(b);
					end
					"E": begin
						exp_addr.push_back(a);
						exp_data.push_back(b);
					end
					// Offset is relative to the joystick value of this run
					"J": begin
						exp_addr.push_back(a);
						exp_data.push_back(joystick_data + b);
					end
					default: begin
						$display("Unknown line kind in cpu_patterns.txt");
						errors++;
					end
				endcase
				if ((kind == "E" || kind == "J") && !a[`MMIO_BIT]) begin
					$display("Expected write address %h is outside the I/O region", a);
					errors++;
				end
			end
		end
		$fclose(fd);

		// A store just past the program must never issue once ECALL is fetched
		next_addr = '0;
		foreach (prog_addr[i]) begin
			if (prog_addr[i] + 32'd4 > next_addr)
				next_addr = prog_addr[i] + 32'd4;
		end
		prog_addr.push_back(next_addr);
		prog_word.push_back(STRAY_STORE);

		if (prog_addr.size() > 2**`IMEM_AW) begin
			$display("Program does not fit into instruction memory");
			errors++;
		end
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (boot_ack !== level && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (boot_ack !== level) begin
			$display("Timed out waiting for boot_ack to go %b", level);
			timeouts++;
		end
	endtask

	task automatic boot_word(input pipe_pkg::word_t addr, input pipe_pkg::word_t data);
		check_bit($sformatf("boot_ack idle before %h", addr), 1'b0, boot_ack);
		boot_addr = addr;
		boot_data = data;
		boot_req  = 1'b1;
		wait_ack(1'b1);
		// Acknowledge holds as long as the request stays up
		@(negedge clk);
		check_bit($sformatf("boot_ack held for %h", addr), 1'b1, boot_ack);
		boot_req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic wait_writes(input int count);
		int cycles;
		cycles = 0;
		while (seen < count && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (seen < count) begin
			$display("Timed out after %0d of %0d memory-mapped writes", seen, count);
			timeouts++;
		end
	endtask

	task automatic wait_halt();
		int cycles;
		cycles = 0;
		while (halt !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halt !== 1'b1) begin
			$display("Timed out waiting for halt");
			timeouts++;
		end
	endtask

	// Writes are compared in program order as they leave the memory stage
	always @(posedge clk) begin
		if (arst_n && mmio_we === 1'b1) begin
			if (halt === 1'b1) begin
				$display("Memory-mapped write to %h happened after halt", mmio_addr);
				errors++;
			end
			if (seen < exp_addr.size()) begin
				check_word($sformatf("write %0d address", seen), exp_addr[seen], mmio_addr);
				check_word($sformatf("write %0d data", seen), exp_data[seen], mmio_data);
			end else begin
				$display("Unexpected memory-mapped write of %h to %h", mmio_data, mmio_addr);
				errors++;
			end
			seen++;
		end
	end

	initial begin
		errors        = 0;
		timeouts      = 0;
		seen          = 0;
		arst_n        = 1'b0;
		debug         = 1'b1;
		boot_req      = 1'b0;
		boot_addr     = '0;
		boot_data     = '0;
		void'($urandom(11));
		joystick_data = $urandom();
		load_patterns();

		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_bit("boot_ack after reset", 1'b0, boot_ack);
		check_bit("mmio_we after reset", 1'b0, mmio_we);
		check_bit("halt after reset", 1'b0, halt);

		foreach (prog_addr[i])
			boot_word(prog_addr[i], prog_word[i]);

		debug = 1'b0;
		wait_writes(exp_addr.size());
		wait_halt();

		// Watch for stray writes once the core has stopped
		repeat (20) @(negedge clk);
		check_bit("halt held", 1'b1, halt);
		check_count("memory-mapped write count", exp_addr.size(), seen);

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- cpu_patterns.txt
# P addr word = program word, E addr data = expected I/O write
# J addr offset = expected I/O write of joystick_data plus offset
# ALU, immediates, forwarding
P 00000000 00008537
P 00000004 06400093
P 00000008 FF900113
P 0000000C 002081B3
P 00000010 00352023
P 00000014 40208233
P 00000018 00452223
P 0000001C 0F014293
P 00000020 4042D313
P 00000024 001323B3
P 00000028 00133433
P 0000002C 00539493
P 00000030 0054E5B3
P 00000034 00B52423
P 00000038 00852623
# AUIPC and LUI
P 0000003C 00001697
P 00000040 00D52823
P 00000044 ABCDE737
P 00000048 12370713
P 0000004C 00E52A23
# Data memory and load-use
P 00000050 04E02023
P 00000054 04002783
P 00000058 00178813
P 0000005C 05002223
P 00000060 04402883
P 00000064 01152C23
# Branches, wrong-path stores go to 8100
P 00000068 00500913
P 0000006C FFD00993
P 00000070 01390463
P 00000074 01252E23
P 00000078 01391463
P 0000007C 11352023
P 00000080 0129C463
P 00000084 11352023
P 00000088 0129D463
P 0000008C 03352023
P 00000090 01395463
P 00000094 11352023
P 00000098 01394463
P 0000009C 04402A83
P 000000A0 011A8463
P 000000A4 11352023
# JAL, JALR, joystick load and ECALL
P 000000A8 010000EF
P 000000AC 02152223
P 000000B0 00C0006F
P 000000B4 11352023
P 000000B8 00008067
P 000000BC 00052B03
P 000000C0 055B0B13
P 000000C4 03652423
P 000000C8 00000073
# Expected writes in order
E 00008000 0000005D
E 00008004 0000006B
E 00008008 FFFFFF29
E 0000800C 00000000
E 00008010 0000103C
E 00008014 ABCDE123
E 00008018 ABCDE124
E 0000801C 00000005
E 00008020 FFFFFFFD
E 00008024 000000AC
J 00008028 00000055

//--- sim.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
hazard_unit.sv
cpu.sv
tb_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_cpu -f sim.f
output="$(./obj_dir/Vtb_cpu)"
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
	exit 0
else
	exit 1
fi
